/* ipv4_frame_filter.f */
+incdir+rtl
rtl/filter_pkg.sv
rtl/ip_header_parser.sv
rtl/ip_blacklist.sv
rtl/frame_buffer.sv
rtl/frame_forwarder.sv
rtl/ipv4_frame_filter.sv
dv/ipv4_frame_filter_sva.sv
dv/ipv4_frame_filter_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timescale 1ns/1ns -Wno-fatal
TOP       ?= ipv4_frame_filter_tb
FILELIST  ?= ipv4_frame_filter.f
SIM       := obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

/* dv/ipv4_frame_filter_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module ipv4_frame_filter_tb;

    // Header layout of an Ethernet frame carrying IPv4
    localparam int SRC_OFF      = 26;
    localparam int DST_OFF      = 30;
    localparam int HDR_BYTES    = 34;
    localparam int CYCLE_LIMIT  = 4000;
    localparam int QUIET_CYCLES = 100;

    logic              clk;
    logic              rst;
    filter_pkg::byte_t in_data;
    logic              in_valid;
    logic              in_last;
    filter_pkg::byte_t out_data;
    logic              out_valid;
    logic              out_last;

    int unsigned lcg_state;
    int unsigned cycle_cnt = 0;

    // Entries are {last, byte}
    logic [8:0] observed [$];
    logic [8:0] expected [$];
    logic [7:0] frame_bytes [$];

    ipv4_frame_filter ipv4_frame_filter_i (
        .clk       (clk),
        .rst       (rst),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_last   (in_last),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_last  (out_last)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // ------------------------------
    // Helpers
    // ------------------------------

    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {16'd0, lcg_state[31:16]};
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = next_rand();
        return r[7:0];
    endfunction

    // 192.168.0.1 to 192.168.0.4
    function automatic logic [31:0] blocked_addr(input int unsigned idx);
        return 32'hC0A8_0001 + (idx % 4);
    endfunction

    // 10.x.y.z never hits the table
    function automatic logic [31:0] clean_addr();
        return {8'h0A, rand_byte(), rand_byte(), rand_byte()};
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] wanted,
                               input string what);
        if (actual !== wanted) begin
            $display("Error at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, wanted);
            $display("SOME TESTS FAILED");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    // Random payload with addresses placed only where the frame is long enough
    task automatic build_frame(input int len, input logic [31:0] src, input logic [31:0] dst);
        frame_bytes.delete();
        for (int i = 0; i < len; i++) begin
            frame_bytes.push_back(rand_byte());
        end
        for (int k = 0; k < 4; k++) begin
            if (SRC_OFF + k < len) frame_bytes[SRC_OFF + k] = src[31 - 8 * k -: 8];
            if (DST_OFF + k < len) frame_bytes[DST_OFF + k] = dst[31 - 8 * k -: 8];
        end
    endtask

    task automatic expect_frame();
        for (int i = 0; i < frame_bytes.size(); i++) begin
            expected.push_back({(i == frame_bytes.size() - 1), frame_bytes[i]});
        end
    endtask

    // Random idle cycles of up to gap_max before each byte
    task automatic send_frame(input int gap_max);
        int gaps;
        for (int i = 0; i < frame_bytes.size(); i++) begin
            gaps = (gap_max > 0) ? int'(next_rand() % (gap_max + 1)) : 0;
            repeat (gaps) begin
                @(posedge clk);
                #5;
                in_valid = 1'b0;
                in_last  = 1'b0;
            end
            @(posedge clk);
            #5;
            in_data  = frame_bytes[i];
            in_valid = 1'b1;
            in_last  = (i == frame_bytes.size() - 1);
        end
    endtask

    task automatic idle_input();
        @(posedge clk);
        #5;
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    // Wait for every expected byte and then a quiet window longer than any dropped frame
    task automatic wait_quiet();
        int idle;
        idle = 0;
        while (idle < QUIET_CYCLES || observed.size() < expected.size()) begin
            @(negedge clk);
            if (out_valid) idle = 0;
            else idle++;
        end
    endtask

    task automatic compare_output(input string name);
        check_equal(observed.size(), expected.size(), {name, " output byte count"});
        for (int i = 0; i < expected.size(); i++) begin
            check_equal(observed[i], expected[i], $sformatf("%s byte %0d", name, i));
        end
        observed.delete();
        expected.delete();
    endtask

    // ------------------------------
    // Monitor and timeout
    // ------------------------------

    // Registered outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst && out_valid) observed.push_back({out_last, out_data});
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("SOME TESTS FAILED");
            $fatal(1, "Timeout, tests still running after %0d cycles", CYCLE_LIMIT);
        end
    end

    // ------------------------------
    // Directed tests
    // ------------------------------

    task automatic test_clean_frame();
        repeat (5) begin
            @(negedge clk);
            check_equal(out_valid, 1'b0, "out_valid after reset");
        end
        build_frame(60, clean_addr(), clean_addr());
        expect_frame();
        send_frame(3);
        idle_input();
        wait_quiet();
        compare_output("clean frame");
    endtask

    task automatic test_src_blocked();
        build_frame(60, blocked_addr(next_rand()), clean_addr());
        send_frame(0);
        idle_input();
        wait_quiet();
        compare_output("blocked source");
    endtask

    task automatic test_dst_blocked();
        build_frame(60, clean_addr(), blocked_addr(next_rand()));
        send_frame(0);
        idle_input();
        wait_quiet();
        compare_output("blocked destination");
    endtask

    // Runt has a source but no destination address
    // Leading clean frame leaves no blocked address in the parser for the runt to inherit
    task automatic test_runt();
        build_frame(40, clean_addr(), clean_addr());
        expect_frame();
        send_frame(0);
        build_frame(30, clean_addr(), clean_addr());
        send_frame(0);
        build_frame(50, clean_addr(), clean_addr());
        expect_frame();
        send_frame(1);
        idle_input();
        wait_quiet();
        compare_output("runt then clean");
    endtask

    task automatic test_mixed_burst();
        int          len;
        int unsigned pick;
        logic [31:0] src;
        logic [31:0] dst;
        for (int f = 0; f < 8; f++) begin
            len  = HDR_BYTES + int'(next_rand() % 47);
            pick = next_rand() % 4;
            src  = (pick == 1 || pick == 3) ? blocked_addr(next_rand()) : clean_addr();
            dst  = (pick == 2 || pick == 3) ? blocked_addr(next_rand()) : clean_addr();
            build_frame(len, src, dst);
            if (pick == 0) expect_frame();
            send_frame(0);
        end
        idle_input();
        wait_quiet();
        compare_output("mixed burst");
    endtask

    initial begin
        lcg_state = 5703;
        in_data   = '0;
        in_valid  = 1'b0;
        in_last   = 1'b0;
        rst       = 1'b1;
        repeat (10) @(posedge clk);
        #5;
        rst = 1'b0;

        test_clean_frame();
        test_src_blocked();
        test_dst_blocked();
        test_runt();
        test_mixed_burst();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/ipv4_frame_filter_sva.sv */
`timescale 1ns/1ns
`default_nettype none

module ipv4_frame_filter_sva (
    input wire clk,
    input wire rst,
    input wire wr_en,
    input wire rd_en,
    input wire empty,
    input wire full
);

    // ------------------------------
    // Frame buffer usage
    // ------------------------------

    // Sender keeps within the buffer depth
    no_write_when_full_a: assert property (
        @(posedge clk) disable iff (rst) full |-> !wr_en
    ) else $error("Frame buffer written while full");

    // Forwarder only pops stored bytes
    no_read_when_empty_a: assert property (
        @(posedge clk) disable iff (rst) empty |-> !rd_en
    ) else $error("Frame buffer read while empty");

    // Reads stay off through reset
    no_read_in_reset_a: assert property (
        @(posedge clk) rst |-> !rd_en
    ) else $error("Frame buffer read during reset");

endmodule

bind frame_buffer ipv4_frame_filter_sva buffer_sva_i (
    .clk   (clk),
    .rst   (rst),
    .wr_en (wr_en),
    .rd_en (rd_en),
    .empty (empty),
    .full  (full)
);

`default_nettype wire

/* rtl/ipv4_frame_filter.sv */
`timescale 1ns/1ns
`default_nettype none

module ipv4_frame_filter (
    input  wire                     clk,
    input  wire                     rst,
    input  wire filter_pkg::byte_t  in_data,
    input  wire                     in_valid,
    input  wire                     in_last,
    output filter_pkg::byte_t       out_data,
    output logic                    out_valid,
    output logic                    out_last
);

    // Parser to blacklist
    filter_pkg::ipv4_addr_u src_addr;
    filter_pkg::ipv4_addr_u dst_addr;
    logic                   hdr_ok;
    logic                   frame_done;

    // Blacklist to forwarder
    logic                   verdict_valid;
    logic                   verdict_drop;

    // Buffer read side
    filter_pkg::byte_t      rd_data;
    logic                   rd_last;
    logic                   buf_empty;
    logic                   rd_en;

    // ------------------------------
    // Producer, header and lookup
    // ------------------------------

    ip_header_parser u_parser (
        .clk        (clk),
        .rst        (rst),
        .in_data    (in_data),
        .in_valid   (in_valid),
        .in_last    (in_last),
        .src_addr   (src_addr),
        .dst_addr   (dst_addr),
        .hdr_ok     (hdr_ok),
        .frame_done (frame_done)
    );

    ip_blacklist u_blacklist (
        .clk           (clk),
        .rst           (rst),
        .src_addr      (src_addr),
        .dst_addr      (dst_addr),
        .hdr_ok        (hdr_ok),
        .frame_done    (frame_done),
        .verdict_valid (verdict_valid),
        .verdict_drop  (verdict_drop)
    );

    // Every input byte is stored, verdict or not
    frame_buffer u_buffer (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (in_valid),
        .wr_data (in_data),
        .wr_last (in_last),
        .rd_en   (rd_en),
        .rd_data (rd_data),
        .rd_last (rd_last),
        .empty   (buf_empty),
        .full    ()
    );

    // ------------------------------
    // Consumer
    // ------------------------------

    frame_forwarder u_forwarder (
        .clk           (clk),
        .rst           (rst),
        .verdict_valid (verdict_valid),
        .verdict_drop  (verdict_drop),
        .rd_data       (rd_data),
        .rd_last       (rd_last),
        .empty         (buf_empty),
        .rd_en         (rd_en),
        .out_data      (out_data),
        .out_valid     (out_valid),
        .out_last      (out_last)
    );

endmodule

`default_nettype wire

/* rtl/frame_forwarder.sv */
`timescale 1ns/1ns
`default_nettype none

`include "filter_config.svh"

module frame_forwarder (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     verdict_valid,
    input  wire                     verdict_drop,
    input  wire filter_pkg::byte_t  rd_data,
    input  wire                     rd_last,
    input  wire                     empty,
    output logic                    rd_en,
    output filter_pkg::byte_t       out_data,
    output logic                    out_valid,
    output logic                    out_last
);

    localparam int unsigned Q_DEPTH = `VERDICT_DEPTH;
    localparam int unsigned Q_PTR_W = $clog2(Q_DEPTH);
    localparam logic [Q_PTR_W-1:0] Q_PTR_LAST = Q_PTR_W'(Q_DEPTH - 1);

    typedef enum logic {
        ST_IDLE,
        ST_STREAM
    } state_t;

    state_t state;

    // Verdict queue, one drop bit per finished frame
    logic               q_drop [Q_DEPTH];
    logic [Q_PTR_W-1:0] q_wr_ptr;
    logic [Q_PTR_W-1:0] q_rd_ptr;
    logic [Q_PTR_W:0]   q_count;
    logic               q_pop;
    logic               head_drop;

    // ------------------------------
    // Verdict queue
    // ------------------------------

    always_ff @(posedge clk) begin
        if (verdict_valid) begin
            q_drop[q_wr_ptr] <= verdict_drop;
        end
    end

    assign head_drop = q_drop[q_rd_ptr];

    // Head leaves once its last byte has been popped
    assign q_pop = rd_en && rd_last;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            q_wr_ptr <= '0;
            q_rd_ptr <= '0;
            q_count  <= '0;
        end else begin
            if (verdict_valid) begin
                q_wr_ptr <= (q_wr_ptr == Q_PTR_LAST) ? '0 : q_wr_ptr + 1'b1;
            end
            if (q_pop) begin
                q_rd_ptr <= (q_rd_ptr == Q_PTR_LAST) ? '0 : q_rd_ptr + 1'b1;
            end
            case ({verdict_valid, q_pop})
                2'b10:   q_count <= q_count + 1'b1;
                2'b01:   q_count <= q_count - 1'b1;
                default: q_count <= q_count;
            endcase
        end
    end

    // ------------------------------
    // Frame FSM
    // ------------------------------

    // A verdict only exists once its whole frame sits in the buffer
    // so a frame streams out without holes
    assign rd_en = (state == ST_STREAM) && !empty;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (q_count != '0) begin
                        state <= ST_STREAM;
                    end
                end
                ST_STREAM: begin
                    if (q_pop) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Output register, dropped bytes are popped without a strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            out_valid <= rd_en && !head_drop;
            out_last  <= q_pop && !head_drop;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en && !head_drop) begin
            out_data <= rd_data;
        end
    end

endmodule

`default_nettype wire

/* rtl/frame_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "filter_config.svh"

module frame_buffer (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     wr_en,
    input  wire filter_pkg::byte_t  wr_data,
    input  wire                     wr_last,
    input  wire                     rd_en,
    output filter_pkg::byte_t       rd_data,
    output logic                    rd_last,
    output logic                    empty,
    output logic                    full
);

    localparam int unsigned DEPTH = `FRAME_BUF_DEPTH;
    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
    localparam logic [PTR_W:0]   CNT_FULL = (PTR_W + 1)'(DEPTH);

    // Entry layout is {last, byte}
    logic [`BYTE_W:0]   mem [DEPTH];
    logic [`BYTE_W:0]   head;
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     count;

    // ------------------------------
    // Storage
    // ------------------------------

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= {wr_last, wr_data};
        end
    end

    // First word falls through, visible the cycle after its write
    assign head    = mem[rd_ptr];
    assign rd_data = head[`BYTE_W-1:0];
    assign rd_last = head[`BYTE_W];

    assign empty = (count == '0);
    assign full  = (count == CNT_FULL);

    // ------------------------------
    // Pointers and occupancy
    // ------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the count as is
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/ip_blacklist.sv */
`timescale 1ns/1ns
`default_nettype none

`include "filter_config.svh"

module ip_blacklist (
    input  wire                         clk,
    input  wire                         rst,
    input  wire filter_pkg::ipv4_addr_u src_addr,
    input  wire filter_pkg::ipv4_addr_u dst_addr,
    input  wire                         hdr_ok,
    input  wire                         frame_done,
    output logic                        verdict_valid,
    output logic                        verdict_drop
);

    // Fixed table of blocked addresses
    localparam logic [31:0] BLACKLIST [`BLACKLIST_SIZE] = '{
        `BLACKLIST_0,
        `BLACKLIST_1,
        `BLACKLIST_2,
        `BLACKLIST_3
    };

    logic src_hit;
    logic dst_hit;

    // ------------------------------
    // Table compare
    // ------------------------------

    // Both words checked against every entry in parallel
    always_comb begin
        src_hit = 1'b0;
        dst_hit = 1'b0;
        for (int i = 0; i < `BLACKLIST_SIZE; i++) begin
            if (src_addr.word == BLACKLIST[i]) begin
                src_hit = 1'b1;
            end
            if (dst_addr.word == BLACKLIST[i]) begin
                dst_hit = 1'b1;
            end
        end
    end

    // Runts carry no usable header and are always dropped
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            verdict_valid <= 1'b0;
            verdict_drop  <= 1'b0;
        end else begin
            verdict_valid <= frame_done;
            if (frame_done) begin
                verdict_drop <= !hdr_ok || src_hit || dst_hit;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/ip_header_parser.sv */
`timescale 1ns/1ns
`default_nettype none

`include "filter_config.svh"

module ip_header_parser (
    input  wire                     clk,
    input  wire                     rst,
    input  wire filter_pkg::byte_t  in_data,
    input  wire                     in_valid,
    input  wire                     in_last,
    output filter_pkg::ipv4_addr_u  src_addr,
    output filter_pkg::ipv4_addr_u  dst_addr,
    output logic                    hdr_ok,
    output logic                    frame_done
);

    localparam logic [`BYTE_CNT_W-1:0] SRC_OFF   = `SRC_IP_OFFSET;
    localparam logic [`BYTE_CNT_W-1:0] DST_OFF   = `DST_IP_OFFSET;
    localparam logic [`BYTE_CNT_W-1:0] HDR_LAST  = `HDR_END_OFFSET - 1;
    localparam logic [`BYTE_CNT_W-1:0] IP_OCTETS = 4;
    localparam logic [`BYTE_CNT_W-1:0] CNT_MAX   = '1;

    // Index of the current byte inside its frame
    logic [`BYTE_CNT_W-1:0] byte_cnt;
    logic [`BYTE_CNT_W-1:0] src_rel;
    logic [`BYTE_CNT_W-1:0] dst_rel;
    logic                   in_src;
    logic                   in_dst;

    // Addresses being assembled for the frame in flight
    filter_pkg::ipv4_addr_u src_acc;
    filter_pkg::ipv4_addr_u dst_acc;
    filter_pkg::ipv4_addr_u src_nxt;
    filter_pkg::ipv4_addr_u dst_nxt;

    // ------------------------------
    // Octet placement
    // ------------------------------

    assign src_rel = byte_cnt - SRC_OFF;
    assign dst_rel = byte_cnt - DST_OFF;
    assign in_src  = (byte_cnt >= SRC_OFF) && (src_rel < IP_OCTETS);
    assign in_dst  = (byte_cnt >= DST_OFF) && (dst_rel < IP_OCTETS);

    // Merge the current byte so the last byte can complete an address
    always_comb begin
        src_nxt = src_acc;
        dst_nxt = dst_acc;
        if (in_valid && in_src) begin
            src_nxt.octet[src_rel[1:0]] = in_data;
        end
        if (in_valid && in_dst) begin
            dst_nxt.octet[dst_rel[1:0]] = in_data;
        end
    end

    always_ff @(posedge clk) begin
        src_acc <= src_nxt;
        dst_acc <= dst_nxt;
        // Outputs freeze at end of frame until the next one ends
        if (in_valid && in_last) begin
            src_addr <= src_nxt;
            dst_addr <= dst_nxt;
        end
    end

    // ------------------------------
    // Byte count and frame end
    // ------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            byte_cnt   <= '0;
            hdr_ok     <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= in_valid && in_last;
            if (in_valid) begin
                if (in_last) begin
                    // Frame length is byte_cnt + 1
                    hdr_ok   <= (byte_cnt >= HDR_LAST);
                    byte_cnt <= '0;
                end else if (byte_cnt != CNT_MAX) begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/filter_pkg.sv */
`default_nettype none

`include "filter_config.svh"

package filter_pkg;

    // One byte of the frame stream
    typedef logic [`BYTE_W-1:0] byte_t;

    // IPv4 address, seen as one word or as four octets
    // Octet 0 arrives first on the wire and is the most significant
    typedef union packed {
        logic [31:0]     word;
        byte_t [0:3]     octet;
    } ipv4_addr_u;

endpackage

`default_nettype wire

/* rtl/filter_config.svh */
`ifndef FILTER_CONFIG_SVH
`define FILTER_CONFIG_SVH

// ------------------------------
// Stream format
// ------------------------------

// Width of one byte on the in_ and out_ streams
`define BYTE_W 8

// ------------------------------
// IPv4 header layout
// ------------------------------

// Byte index of the first source octet
// Counted from the first byte of the Ethernet frame
`define SRC_IP_OFFSET 26

// Byte index of the first destination octet
`define DST_IP_OFFSET 30

// A frame needs at least this many bytes to carry both addresses
`define HDR_END_OFFSET 34

// In-frame byte counter width, saturates at all ones
`define BYTE_CNT_W 11

// ------------------------------
// Blacklist table
// ------------------------------

`define BLACKLIST_SIZE 4

// 192.168.0.1 to 192.168.0.4
`define BLACKLIST_0 32'hC0A8_0001
`define BLACKLIST_1 32'hC0A8_0002
`define BLACKLIST_2 32'hC0A8_0003
`define BLACKLIST_3 32'hC0A8_0004

// ------------------------------
// Buffer sizes
// ------------------------------

// Byte FIFO entries, each with an end-of-frame bit
`define FRAME_BUF_DEPTH 256

// Verdicts that may wait for their frame
`define VERDICT_DEPTH 4

`endif
